/* Makefile */
LOG := sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f filelist.f --top-module simtGroupTb -Mdir obj_dir

run: compile
	./obj_dir/VsimtGroupTb > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "Errors found" $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/clockGen.sv */
`timescale 1ns/100ps

module clockGen #(
    parameter int periodNs    = 40,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;                  // released on a rising edge
    end

    always #(periodNs / 2) clk = ~clk;

endmodule

/* bench/simtGroupTb.sv */
`timescale 1ns/100ps

module simtGroupTb;
    import simtPkg::*;

    localparam int numLanes   = 4;
    localparam int periodNs   = 40;
    localparam int numImm     = 40;
    localparam int numAlu     = 40;
    localparam int numShift   = 16;
    localparam int numChain   = 16;
    // lane-number read, the halt and the refused request on top
    localparam int numInstr   = 1 + numImm + numAlu + numShift + numChain + 2;
    localparam int watchdogNs = numInstr * 10 * periodNs + 40 * periodNs;

    typedef struct packed {
        regAddr_t                 dst;
        int                       due;      // cycle count when the trace shows
        word_t [numLanes-1:0]     data;
    } expect_t;

    logic                         clk, reset, instrReq, instrAck, halt;
    instr_t                       instr;
    logic [numLanes-1:0]          wbValid;
    regAddr_t [numLanes-1:0]      wbAddr;
    word_t [numLanes-1:0]         wbData;
    int                           cycle;
    word_t                        modelRegs [numLanes][32];
    expect_t                      expQ [$];
    opcode_t                      immOps [5] = '{opAddi, opAndi, opOri, opLui, opMuli};
    logic [5:0]                   aluFuncts [5] = '{6'd32, 6'd34, 6'd36, 6'd37, 6'd42};

    clockGen #(.periodNs(periodNs), .resetCycles(3)) i_clockGen (.clk(clk), .reset(reset));

    simtGroup #(.numLanes(numLanes)) i_simtGroup (
        .clk(clk), .reset(reset), .instrReq(instrReq), .instr(instr), .instrAck(instrAck),
        .halt(halt), .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
    );

    //////////////////////////////////////////////////
    // reference model
    function automatic word_t refCompute(instr_t i, word_t a, word_t b);
        logic [15:0] imm;
        word_t       sImm;
        imm  = i[15:0];
        sImm = {{16{imm[15]}}, imm};
        case (i[31:26])
            6'd0:
                case (i[5:0])
                    6'd34:   return a - b;
                    6'd36:   return a & b;
                    6'd37:   return a | b;
                    6'd42:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'd0:    return b << i[10:6];
                    6'd2:    return b >> i[10:6];
                    default: return a + b;      // unknown funct is an add
                endcase
            6'd8:    return a + sImm;
            6'd10:   return a * {15'd0, sImm[16:0]};
            6'd12:   return a & {16'd0, imm};
            6'd13:   return a | {16'd0, imm};
            6'd15:   return {imm, 16'd0};
            default: return '0;
        endcase
    endfunction

    // zero means nothing is written
    function automatic regAddr_t refDest(instr_t i);
        case (i[31:26])
            6'd0:                     return i[15:11];
            6'd8, 6'd10, 6'd12, 6'd13, 6'd15: return i[20:16];
            default:                  return '0;
        endcase
    endfunction

    task automatic predict(input instr_t i, input int acceptCycle);
        expect_t e;
        e.dst = refDest(i);
        e.due = acceptCycle + 3;
        for (int l = 0; l < numLanes; l++)
            e.data[l] = refCompute(i, modelRegs[l][i[25:21]], modelRegs[l][i[20:16]]);
        if (e.dst != '0)
        begin
            for (int l = 0; l < numLanes; l++)
                modelRegs[l][e.dst] = e.data[l];
            expQ.push_back(e);
        end
    endtask

    //////////////////////////////////////////////////
    // checks
    task automatic stopOnError();
        $display("Errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkAddr(input string name, input regAddr_t got, input regAddr_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stopOnError();
        end
    endtask

    always @(posedge clk or posedge reset)
        if (reset)
            cycle <= 0;
        else
            cycle <= cycle + 1;

    // trace compare at the falling edge
    always @(negedge clk)
    begin
        expect_t e;
        if (!reset && (wbValid != '0))
        begin
            if (expQ.size() == 0)
            begin
                $display("a writeback showed up with no instruction expecting one");
                stopOnError();
            end
            else
            begin
                e = expQ.pop_front();
                if (cycle != e.due)
                begin
                    $display("writeback came at cycle %0d, due at cycle %0d", cycle, e.due);
                    stopOnError();
                end
                else
                begin
                    for (int l = 0; l < numLanes; l++)
                    begin
                        checkFlag($sformatf("wbValid[%0d]", l), wbValid[l], 1'b1);
                        checkAddr($sformatf("wbAddr[%0d]", l), wbAddr[l], e.dst);
                        checkWord($sformatf("wbData[%0d]", l), wbData[l], e.data[l]);
                    end
                end
            end
        end
    end

    initial
    begin
        #(watchdogNs);
        $display("the run timed out before all instructions were done");
        stopOnError();
    end

    //////////////////////////////////////////////////
    // stimulus
    function automatic instr_t rType(logic [5:0] f, regAddr_t rs, regAddr_t rt, regAddr_t rd,
                                     logic [4:0] shamt);
        return {6'd0, rs, rt, rd, shamt, f};
    endfunction

    function automatic instr_t iType(opcode_t op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // raise req and wait for ack, then drop req and wait for ack low
    task automatic sendInstr(input instr_t i, output int acceptCycle);
        @(posedge clk);
        instr    <= i;
        instrReq <= 1'b1;
        do @(negedge clk); while (instrAck !== 1'b1);
        acceptCycle = cycle;
        predict(i, acceptCycle);
        @(posedge clk);
        instrReq <= 1'b0;
        do @(negedge clk); while (instrAck !== 1'b0);
    endtask

    initial
    begin
        int         acc;
        regAddr_t   dst;
        regAddr_t   prev;
        logic [5:0] funct;
        instrReq = 1'b0;
        instr    = '0;
        void'($urandom(10313));
        for (int l = 0; l < numLanes; l++)
            for (int r = 0; r < 32; r++)
                modelRegs[l][r] = (r == laneIdReg) ? word_t'(l) : '0;
        wait (reset === 1'b0);
        @(negedge clk);
        checkFlag("instrAck", instrAck, 1'b0);
        checkFlag("halt", halt, 1'b0);
        for (int l = 0; l < numLanes; l++)
            checkFlag($sformatf("wbValid[%0d]", l), wbValid[l], 1'b0);
        sendInstr(rType(6'd32, 5'd26, 5'd0, 5'd30, 5'd0), acc);   // lane number into r30
        for (int k = 0; k < numImm; k++)        // immediates that also fill the registers
        begin
            dst = regAddr_t'(1 + $urandom % 25);
            sendInstr(iType(immOps[$urandom % 5], regAddr_t'($urandom), dst, 16'($urandom)), acc);
        end
        for (int k = 0; k < numAlu; k++)
        begin
            funct = (k % 5 == 4) ? 6'(17 + $urandom % 8) : aluFuncts[$urandom % 5];
            dst   = regAddr_t'(1 + $urandom % 25);
            sendInstr(rType(funct, regAddr_t'($urandom), regAddr_t'($urandom), dst,
                            5'($urandom)), acc);
        end
        for (int k = 0; k < numShift; k++)      // sll and srl
        begin
            dst = regAddr_t'(1 + $urandom % 25);
            sendInstr(rType((k % 2 == 0) ? 6'd0 : 6'd2, regAddr_t'($urandom),
                            regAddr_t'($urandom), dst, 5'($urandom)), acc);
        end
        prev = 5'd26;
        for (int k = 0; k < numChain; k++)      // dependent chain with some writes to r0
        begin
            dst = (k % 4 == 3) ? 5'd0 : regAddr_t'(1 + $urandom % 25);
            if (k % 2 == 0)
                sendInstr(rType(6'd32, prev, 5'd26, dst, 5'd0), acc);
            else
                sendInstr(iType(opAddi, prev, dst, 16'($urandom)), acc);
            if (dst != '0)
                prev = dst;
        end
        sendInstr(iType(opHalt, 5'd0, 5'd0, 16'd0), acc);
        while (cycle < acc + 3) @(negedge clk);
        checkFlag("halt", halt, 1'b0);
        @(negedge clk);
        checkFlag("halt", halt, 1'b1);
        @(posedge clk);
        instr    <= rType(6'd32, 5'd1, 5'd2, 5'd3, 5'd0);
        instrReq <= 1'b1;
        repeat (20)
        begin
            @(negedge clk);
            checkFlag("instrAck", instrAck, 1'b0);
        end
        @(posedge clk);
        instrReq <= 1'b0;
        repeat (4) @(negedge clk);
        if (expQ.size() != 0)
        begin
            $display("%0d expected writebacks never arrived", expQ.size());
            stopOnError();
        end
        else
        begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* common/simtPkg.sv */
package simtPkg;

    //////////////////////////////////////////////////
    // widths
    parameter int dataWidth    = 32;
    parameter int regAddrWidth = 5;
    parameter int laneIdReg    = 26;   // holds the lane number out of reset

    typedef logic [dataWidth-1:0]    word_t;
    typedef logic [31:0]             instr_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    //////////////////////////////////////////////////
    // encodings
    typedef enum logic [5:0] {
        opRtype = 6'd0,
        opAddi  = 6'd8,
        opMuli  = 6'd10,
        opAndi  = 6'd12,
        opOri   = 6'd13,
        opHalt  = 6'd14,
        opLui   = 6'd15
    } opcode_t;

    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSub = 3'b110,
        aluSlt = 3'b111
    } aluOp_t;

    typedef enum logic [1:0] {
        shNone = 2'b00,
        shSll  = 2'b01,
        shSrl  = 2'b10
    } shiftOp_t;

    // all fields zero means nop
    typedef struct packed {
        logic     regWrite;
        logic     regDst;     // rd instead of rt
        logic     zeroImm;
        logic     aluSrc;     // immediate as operand b
        aluOp_t   aluOp;
        shiftOp_t shiftOp;
        logic     isMul;
        logic     immToReg;   // lui
        logic     isHalt;
    } ctrl_t;

    //////////////////////////////////////////////////
    // stage payloads
    typedef struct packed {
        ctrl_t         ctrl;
        word_t         rsData;
        word_t         rtData;
        word_t         imm;
        logic [4:0]    shamt;
        regAddr_t      dst;
        regAddr_t      rs;
        regAddr_t      rt;
    } execPayload_t;

    typedef struct packed {
        ctrl_t         ctrl;
        word_t         aluRes;
        word_t         shiftRes;
        word_t         mulA;
        logic [16:0]   mulB;       // low immediate bits that also feed lui
        regAddr_t      dst;
    } memPayload_t;

    typedef struct packed {
        logic          regWrite;
        logic          isHalt;
        regAddr_t      dst;
        word_t         result;
    } wbPayload_t;

    // instruction fields
    function automatic opcode_t opcodeOf(instr_t i);
        return opcode_t'(i[31:26]);
    endfunction

    function automatic logic [5:0] functOf(instr_t i);
        return i[5:0];
    endfunction

    function automatic regAddr_t rsOf(instr_t i);
        return i[25:21];
    endfunction

    function automatic regAddr_t rtOf(instr_t i);
        return i[20:16];
    endfunction

    function automatic regAddr_t rdOf(instr_t i);
        return i[15:11];
    endfunction

    function automatic logic [4:0] shamtOf(instr_t i);
        return i[10:6];
    endfunction

    function automatic logic [15:0] immOf(instr_t i);
        return i[15:0];
    endfunction

endpackage

/* filelist.f */
common/simtPkg.sv
hdl/stageReg.sv
hdl/ctrlDecode.sv
hdl/instrIssue.sv
lane/laneRegFile.sv
lane/laneDatapath.sv
hdl/simtGroup.sv
bench/clockGen.sv
bench/simtGroupTb.sv

/* hdl/ctrlDecode.sv */
`timescale 1ns/100ps

module ctrlDecode (
    input  simtPkg::instr_t instrDec,
    output simtPkg::ctrl_t  ctrl
);
    import simtPkg::*;

    always_comb
    begin
        ctrl = '0;                          // unknown opcode stays a nop
        case (opcodeOf(instrDec))
            opRtype:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1;
                ctrl.aluOp    = aluAdd;
                case (functOf(instrDec))
                    6'd34:   ctrl.aluOp   = aluSub;
                    6'd36:   ctrl.aluOp   = aluAnd;
                    6'd37:   ctrl.aluOp   = aluOr;
                    6'd42:   ctrl.aluOp   = aluSlt;
                    6'd0:    ctrl.shiftOp = shSll;
                    6'd2:    ctrl.shiftOp = shSrl;
                    default: ctrl.aluOp   = aluAdd;   // odd funct acts as add
                endcase
            end
            opAddi:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            opMuli:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.isMul    = 1'b1;
            end
            opAndi:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.zeroImm  = 1'b1;
                ctrl.aluOp    = aluAnd;
            end
            opOri:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.zeroImm  = 1'b1;
                ctrl.aluOp    = aluOr;
            end
            opLui:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.immToReg = 1'b1;
            end
            opHalt:  ctrl.isHalt = 1'b1;
            default: ctrl = '0;
        endcase
    end

endmodule

/* hdl/instrIssue.sv */
`timescale 1ns/100ps

module instrIssue (
    input  logic            clk,
    input  logic            reset,
    input  logic            instrReq,
    input  simtPkg::instr_t instr,
    input  logic            haltRetired,
    output logic            instrAck,
    output logic            issue,
    output simtPkg::instr_t instrDec,
    output logic            halt
);
    import simtPkg::*;

    typedef enum logic [1:0] {
        idle,
        acked,
        halted
    } state_t;

    state_t state;

    assign issue = (state == idle) && instrReq;   // accept edge

    //////////////////////////////////////////////////
    // four-phase intake
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state    <= idle;
            instrAck <= 1'b0;
            instrDec <= '0;
        end
        else
        begin
            instrDec <= issue ? instr : '0;      // nop when nothing taken
            case (state)
                idle:
                    if (issue)
                    begin
                        instrAck <= 1'b1;
                        state    <= (opcodeOf(instr) == opHalt) ? halted : acked;
                    end
                acked:
                    if (!instrReq)
                    begin
                        instrAck <= 1'b0;
                        state    <= idle;
                    end
                default:
                    // finish the halt handshake, then stay deaf until reset
                    if (!instrReq)
                        instrAck <= 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            halt <= 1'b0;
        else if (haltRetired)
            halt <= 1'b1;
    end

    // ack only ever answers a request seen on the edge before
    assert property (@(posedge clk) disable iff (reset) $rose(instrAck) |-> $past(instrReq));

endmodule

/* hdl/simtGroup.sv */
`timescale 1ns/100ps

module simtGroup #(
    parameter int numLanes = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                instrReq,
    input  simtPkg::instr_t                     instr,
    output logic                                instrAck,
    output logic                                halt,
    output logic [numLanes-1:0]                 wbValid,
    output simtPkg::regAddr_t [numLanes-1:0]    wbAddr,
    output simtPkg::word_t [numLanes-1:0]       wbData
);
    import simtPkg::*;

    logic                issue;
    instr_t              instrDec;
    ctrl_t               ctrl;
    logic [numLanes-1:0] laneHalt;

    instrIssue i_instrIssue (
        .clk         (clk),
        .reset       (reset),
        .instrReq    (instrReq),
        .instr       (instr),
        .haltRetired (laneHalt[0]),   // lane 0 speaks for the group
        .instrAck    (instrAck),
        .issue       (issue),
        .instrDec    (instrDec),
        .halt        (halt)
    );

    ctrlDecode i_ctrlDecode (
        .instrDec (instrDec),
        .ctrl     (ctrl)
    );

    //////////////////////////////////////////////////
    // lanes on one shared instruction stream
    for (genvar i = 0; i < numLanes; i++)
    begin : gLane
        laneDatapath #(
            .laneId (i)
        ) i_lane (
            .clk         (clk),
            .reset       (reset),
            .instrDec    (instrDec),
            .ctrl        (ctrl),
            .wbValid     (wbValid[i]),
            .wbAddr      (wbAddr[i]),
            .wbData      (wbData[i]),
            .haltRetired (laneHalt[i])
        );
    end

    // every trace entry comes from an accept exactly four edges back
    assert property (@(posedge clk) disable iff (reset) (|wbValid) |-> $past(issue, 4));

endmodule

/* hdl/stageReg.sv */
`timescale 1ns/100ps

module stageReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // zero payload is a nop in every stage
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            q <= '0;
        else if (flush)
            q <= '0;
        else
            q <= d;
    end

endmodule

/* lane/laneDatapath.sv */
`timescale 1ns/100ps

module laneDatapath #(
    parameter int laneId = 0
) (
    input  logic              clk,
    input  logic              reset,
    input  simtPkg::instr_t   instrDec,
    input  simtPkg::ctrl_t    ctrl,
    output logic              wbValid,
    output simtPkg::regAddr_t wbAddr,
    output simtPkg::word_t    wbData,
    output logic              haltRetired
);
    import simtPkg::*;

    execPayload_t ed, eq;
    memPayload_t  md, mq;
    wbPayload_t   wd, wq;
    word_t        rsData, rtData;
    logic [15:0]  imm;
    word_t        rsFwd, rtFwd, srcB, aluRes, shiftRes, selRes;

    //////////////////////////////////////////////////
    // decode
    assign imm         = immOf(instrDec);
    assign ed.ctrl     = ctrl;
    assign ed.rsData   = rsData;
    assign ed.rtData   = rtData;
    assign ed.imm      = ctrl.zeroImm ? {16'b0, imm} : {{16{imm[15]}}, imm};
    assign ed.shamt    = shamtOf(instrDec);
    assign ed.dst      = ctrl.regDst ? rdOf(instrDec) : rtOf(instrDec);
    assign ed.rs       = rsOf(instrDec);
    assign ed.rt       = rtOf(instrDec);

    laneRegFile #(.laneId(laneId)) i_regFile (
        .clk(clk), .reset(reset), .rs(ed.rs), .rt(ed.rt),
        .writeEn(wbValid), .writeAddr(wq.dst), .writeData(wq.result),
        .rsData(rsData), .rtData(rtData)
    );

    stageReg #(.payload_t(execPayload_t)) i_execReg (
        .clk(clk), .reset(reset), .flush(1'b0), .d(ed), .q(eq)
    );

    //////////////////////////////////////////////////
    // execute with result select ahead of writeback
    assign rsFwd = (mq.ctrl.regWrite && (mq.dst != '0) && (mq.dst == eq.rs)) ? selRes :
                   (wbValid && (wq.dst == eq.rs)) ? wq.result : eq.rsData;
    assign rtFwd = (mq.ctrl.regWrite && (mq.dst != '0) && (mq.dst == eq.rt)) ? selRes :
                   (wbValid && (wq.dst == eq.rt)) ? wq.result : eq.rtData;
    assign srcB  = eq.ctrl.aluSrc ? eq.imm : rtFwd;

    always_comb
    begin
        case (eq.ctrl.aluOp)
            aluAnd:  aluRes = rsFwd & srcB;
            aluOr:   aluRes = rsFwd | srcB;
            aluSub:  aluRes = rsFwd - srcB;
            aluSlt:  aluRes = word_t'($signed(rsFwd) < $signed(srcB));
            default: aluRes = rsFwd + srcB;
        endcase
        case (eq.ctrl.shiftOp)
            shSll:   shiftRes = rtFwd << eq.shamt;
            shSrl:   shiftRes = rtFwd >> eq.shamt;
            default: shiftRes = '0;
        endcase
    end

    assign md = '{ctrl: eq.ctrl, aluRes: aluRes, shiftRes: shiftRes,
                  mulA: rsFwd, mulB: eq.imm[16:0], dst: eq.dst};

    stageReg #(.payload_t(memPayload_t)) i_memReg (
        .clk(clk), .reset(reset), .flush(1'b0), .d(md), .q(mq)
    );

    // result select holds the multiply off the execute path
    always_comb
    begin
        if (mq.ctrl.isMul)
            selRes = mq.mulA * word_t'(mq.mulB);          // low 32 bits kept
        else if (mq.ctrl.immToReg)
            selRes = {mq.mulB[15:0], 16'b0};
        else if (mq.ctrl.shiftOp != shNone)
            selRes = mq.shiftRes;
        else
            selRes = mq.aluRes;
    end

    assign wd = '{regWrite: mq.ctrl.regWrite, isHalt: mq.ctrl.isHalt,
                  dst: mq.dst, result: selRes};

    stageReg #(.payload_t(wbPayload_t)) i_wbReg (
        .clk(clk), .reset(reset), .flush(1'b0), .d(wd), .q(wq)
    );

    //////////////////////////////////////////////////
    // writeback and trace
    assign wbValid     = wq.regWrite && (wq.dst != '0);
    assign wbAddr      = wq.dst;
    assign wbData      = wq.result;
    assign haltRetired = wq.isHalt;

endmodule

/* lane/laneRegFile.sv */
`timescale 1ns/100ps

module laneRegFile #(
    parameter int laneId = 0
) (
    input  logic              clk,
    input  logic              reset,
    input  simtPkg::regAddr_t rs,
    input  simtPkg::regAddr_t rt,
    input  logic              writeEn,
    input  simtPkg::regAddr_t writeAddr,
    input  simtPkg::word_t    writeData,
    output simtPkg::word_t    rsData,
    output simtPkg::word_t    rtData
);
    import simtPkg::*;

    word_t regs [2**regAddrWidth];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int r = 0; r < 2**regAddrWidth; r++)
                regs[r] <= (r == laneIdReg) ? word_t'(laneId) : '0;   // lane number preset
        end
        else if (writeEn && (writeAddr != '0))
            regs[writeAddr] <= writeData;
    end

    // r0 reads zero and decode sees a same-cycle write
    assign rsData = (rs == '0) ? '0 : (writeEn && (writeAddr == rs)) ? writeData : regs[rs];
    assign rtData = (rt == '0) ? '0 : (writeEn && (writeAddr == rt)) ? writeData : regs[rt];

    // writeback in the datapath already filters out r0
    assert property (@(posedge clk) disable iff (reset) writeEn |-> (writeAddr != '0));

endmodule
